//--- source/bell_audio_pkg.sv
package bell_audio_pkg;

    // Sample path
    localparam int SAMPLE_W   = 16;
    localparam int BIT_CNT_W  = $clog2(SAMPLE_W);     // Bit index within one word
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // Pitch frame
    localparam int FRAME_LEN   = 64;
    localparam int FRAME_CNT_W = $clog2(FRAME_LEN);
    localparam int BIN_W       = 7;                   // Bins 0 to 64
    typedef logic [BIN_W-1:0] bin_t;

    // Sample FIFO and credits
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int CREDIT_W   = 4;                    // Holds 0 to FIFO_DEPTH
    localparam int OVR_W      = 16;

    // Register map
    localparam int CFG_ADDR_W = 2;
    localparam int CFG_DATA_W = 16;
    localparam logic [CFG_ADDR_W-1:0] REG_K_MIN   = 2'd0;
    localparam logic [CFG_ADDR_W-1:0] REG_K_MAX   = 2'd1;
    localparam logic [CFG_ADDR_W-1:0] REG_THRESH  = 2'd2;
    localparam logic [CFG_ADDR_W-1:0] REG_OVERRUN = 2'd3;  // Read only

    // Reset values
    localparam bin_t K_MIN_RESET = 7'd6;
    localparam bin_t K_MAX_RESET = 7'd10;
    localparam logic [CFG_DATA_W-1:0] THRESH_RESET = 16'd256;

endpackage

//--- source/i2s_capture.sv
`timescale 1ns/1ps

module i2s_capture
    import bell_audio_pkg::*;
(
    input  logic    adc_clk,
    input  logic    reset,
    input  logic    aud_bclk,
    input  logic    aud_adclrck,
    input  logic    aud_adcdat,
    input  logic    credit_return,   // One per FIFO pop
    output logic    sample_push,
    output sample_t sample_data,
    output logic    overrun_inc      // Word dropped, no credit
);

    // Two-flop synchronizers, bit 1 is the safe copy
    logic [1:0] bclk_sync;
    logic [1:0] lrck_sync;
    logic [1:0] dat_sync;

    logic                 bclk_prev;
    logic                 lrck_prev;    // lrck seen at the previous bclk rise
    logic                 bit_rise;
    logic                 lrck_fall;
    logic                 collecting;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic [SAMPLE_W-2:0]  shift_q;      // First 15 bits, MSB first
    logic                 word_done;
    logic [CREDIT_W-1:0]  credits;
    logic                 has_credit;
    logic                 push_now;

    assign bit_rise   = bclk_sync[1] & ~bclk_prev;
    assign lrck_fall  = lrck_prev & ~lrck_sync[1];  // Left slot starts
    assign has_credit = (credits != '0);
    assign push_now   = word_done & has_credit;

    always_ff @(posedge adc_clk) begin
        if (reset) begin
            bclk_sync   <= '0;
            lrck_sync   <= '0;
            dat_sync    <= '0;
            bclk_prev   <= 1'b0;
            lrck_prev   <= 1'b0;
            collecting  <= 1'b0;
            bit_cnt     <= '0;
            word_done   <= 1'b0;
            sample_push <= 1'b0;
            overrun_inc <= 1'b0;
            credits     <= CREDIT_W'(FIFO_DEPTH);  // FIFO starts empty
        end else begin
            bclk_sync   <= {bclk_sync[0], aud_bclk};
            lrck_sync   <= {lrck_sync[0], aud_adclrck};
            dat_sync    <= {dat_sync[0], aud_adcdat};
            bclk_prev   <= bclk_sync[1];
            word_done   <= 1'b0;
            sample_push <= push_now;                  // One cycle after the LSB capture
            overrun_inc <= word_done & ~has_credit;
            if (bit_rise) begin
                lrck_prev <= lrck_sync[1];
                if (lrck_fall) begin
                    // This rise is the one-bit delay, MSB comes next
                    collecting <= 1'b1;
                    bit_cnt    <= '0;
                end else if (collecting) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == BIT_CNT_W'(SAMPLE_W - 1)) begin
                        collecting <= 1'b0;
                        word_done  <= 1'b1;
                    end
                end
            end
            // Credit counter mirrors free FIFO space
            case ({push_now, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;        // Both or neither
            endcase
        end
    end

    // Word assembly, payload only
    always_ff @(posedge adc_clk) begin
        if (bit_rise && collecting && !lrck_fall) begin
            if (bit_cnt == BIT_CNT_W'(SAMPLE_W - 1))
                sample_data <= {shift_q, dat_sync[1]};        // LSB completes the word
            else
                shift_q <= {shift_q[SAMPLE_W-3:0], dat_sync[1]};
        end
    end

endmodule

//--- source/credit_fifo.sv
`timescale 1ns/1ps

module credit_fifo
    import bell_audio_pkg::*;
(
    input  logic    adc_clk,
    input  logic    reset,
    input  logic    sample_push,
    input  sample_t sample_data,
    input  logic    fifo_pop,
    output logic    fifo_valid,
    output sample_t fifo_data,
    output logic    credit_return   // Same cycle as the pop
);

    sample_t               mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [CREDIT_W-1:0]   count;      // Occupancy, 0 to FIFO_DEPTH
    logic                  full;
    logic                  empty;
    logic                  do_push;
    logic                  do_pop;

    assign full    = (count == CREDIT_W'(FIFO_DEPTH));
    assign empty   = (count == '0);
    assign do_push = sample_push & ~full;   // Sender holds a credit, so never full here
    assign do_pop  = fifo_pop & ~empty;

    assign fifo_valid    = ~empty;
    assign fifo_data     = mem[rd_ptr];     // Head of queue
    assign credit_return = do_pop;          // One credit per freed entry

    always_ff @(posedge adc_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;  // Wraps at FIFO_DEPTH
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage has no reset
    always_ff @(posedge adc_clk) begin
        if (do_push)
            mem[wr_ptr] <= sample_data;
    end

endmodule

//--- source/zero_cross_pitch.sv
`timescale 1ns/1ps

module zero_cross_pitch
    import bell_audio_pkg::*;
(
    input  logic                  adc_clk,
    input  logic                  reset,
    input  logic                  fifo_valid,
    input  sample_t               fifo_data,
    input  logic [CFG_DATA_W-1:0] thresh,      // Hysteresis magnitude
    output logic                  fifo_pop,
    output logic                  pitch_valid,
    output bin_t                  pitch_bin
);

    logic signed [SAMPLE_W:0] sample_ext;   // One extra bit for the threshold compare
    logic signed [SAMPLE_W:0] pos_th;
    logic signed [SAMPLE_W:0] neg_th;
    logic                     above;
    logic                     below;
    logic                     sign_q;       // 1 = positive
    logic                     new_sign;
    logic                     changed;
    logic [FRAME_CNT_W-1:0]   sample_idx;
    bin_t                     crossings;
    bin_t                     next_cross;
    bin_t                     rounded;

    // Estimator never stalls
    assign fifo_pop = fifo_valid;

    assign sample_ext = {fifo_data[SAMPLE_W-1], fifo_data};
    assign pos_th     = {1'b0, thresh};
    assign neg_th     = -pos_th;
    assign above      = (sample_ext > pos_th);
    assign below      = (sample_ext < neg_th);

    // Inside the band the previous sign holds
    assign new_sign = above ? 1'b1 : (below ? 1'b0 : sign_q);
    assign changed  = (sample_idx != '0) && (new_sign != sign_q);  // First sample only sets reference

    assign next_cross = crossings + bin_t'(changed);
    assign rounded    = next_cross + 1'b1;   // Max 64, fits BIN_W

    always_ff @(posedge adc_clk) begin
        if (reset) begin
            sign_q      <= 1'b0;
            sample_idx  <= '0;
            crossings   <= '0;
            pitch_valid <= 1'b0;
        end else begin
            pitch_valid <= 1'b0;
            if (fifo_pop) begin
                sign_q     <= new_sign;
                sample_idx <= sample_idx + 1'b1;   // Wraps after FRAME_LEN
                if (sample_idx == FRAME_CNT_W'(FRAME_LEN - 1)) begin
                    crossings   <= '0;             // Next frame starts clean
                    pitch_valid <= 1'b1;
                end else begin
                    crossings <= next_cross;
                end
            end
        end
    end

    // Bin = (crossings + 1) / 2
    always_ff @(posedge adc_clk) begin
        if (fifo_pop && sample_idx == FRAME_CNT_W'(FRAME_LEN - 1))
            pitch_bin <= rounded >> 1;
    end

endmodule

//--- source/bell_band_regs.sv
`timescale 1ns/1ps

module bell_band_regs
    import bell_audio_pkg::*;
(
    input  logic                  adc_clk,
    input  logic                  reset,
    input  logic                  cfg_we,
    input  logic [CFG_ADDR_W-1:0] cfg_addr,
    input  logic [CFG_DATA_W-1:0] cfg_wdata,
    input  logic                  overrun_inc,
    output logic [CFG_DATA_W-1:0] cfg_rdata,
    output bin_t                  k_min,
    output bin_t                  k_max,
    output logic [CFG_DATA_W-1:0] thresh
);

    logic [OVR_W-1:0] overrun_cnt;
    logic             ovr_sat;

    assign ovr_sat = &overrun_cnt;   // Counter stops at all ones

    always_ff @(posedge adc_clk) begin
        if (reset) begin
            k_min       <= K_MIN_RESET;
            k_max       <= K_MAX_RESET;
            thresh      <= THRESH_RESET;
            overrun_cnt <= '0;
        end else begin
            if (cfg_we) begin
                case (cfg_addr)
                    REG_K_MIN:  k_min  <= cfg_wdata[BIN_W-1:0];
                    REG_K_MAX:  k_max  <= cfg_wdata[BIN_W-1:0];
                    REG_THRESH: thresh <= cfg_wdata;
                    default:    ;                    // Overrun is read only
                endcase
            end
            if (overrun_inc && !ovr_sat)
                overrun_cnt <= overrun_cnt + 1'b1;
        end
    end

    // Combinational read
    always_comb begin
        case (cfg_addr)
            REG_K_MIN:  cfg_rdata = CFG_DATA_W'(k_min);    // Zero extended
            REG_K_MAX:  cfg_rdata = CFG_DATA_W'(k_max);
            REG_THRESH: cfg_rdata = thresh;
            default:    cfg_rdata = CFG_DATA_W'(overrun_cnt);
        endcase
    end

endmodule

//--- source/bell_detector.sv
`timescale 1ns/1ps

module bell_detector
    import bell_audio_pkg::*;
(
    input  logic adc_clk,
    input  logic reset,
    input  logic pitch_valid,
    input  bin_t pitch_bin,
    input  bin_t k_min,
    input  bin_t k_max,
    output logic bell_detected,   // Held between frames
    output logic pitch_valid_out,
    output bin_t pitch_bin_out
);

    logic in_band;

    assign in_band = (pitch_bin >= k_min) && (pitch_bin <= k_max);

    always_ff @(posedge adc_clk) begin
        if (reset) begin
            bell_detected   <= 1'b0;
            pitch_valid_out <= 1'b0;
        end else begin
            pitch_valid_out <= pitch_valid;   // Aligned with pitch_bin_out
            if (pitch_valid)
                bell_detected <= in_band;
        end
    end

    always_ff @(posedge adc_clk) begin
        if (pitch_valid)
            pitch_bin_out <= pitch_bin;
    end

endmodule

//--- source/bell_detect_top.sv
`timescale 1ns/1ps

module bell_detect_top
    import bell_audio_pkg::*;
(
    input  logic                  adc_clk,
    input  logic                  reset,
    input  logic                  aud_bclk,
    input  logic                  aud_adclrck,
    input  logic                  aud_adcdat,
    input  logic                  cfg_we,
    input  logic [CFG_ADDR_W-1:0] cfg_addr,
    input  logic [CFG_DATA_W-1:0] cfg_wdata,
    output logic [CFG_DATA_W-1:0] cfg_rdata,
    output logic                  bell_detected,
    output logic                  pitch_valid_out,
    output bin_t                  pitch_bin_out
);

    // Capture to FIFO
    logic    sample_push;
    sample_t sample_data;
    logic    credit_return;
    logic    overrun_inc;

    // FIFO to estimator
    logic    fifo_valid;
    sample_t fifo_data;
    logic    fifo_pop;

    // Estimator and config
    logic                  pitch_valid;
    bin_t                  pitch_bin;
    bin_t                  k_min;
    bin_t                  k_max;
    logic [CFG_DATA_W-1:0] thresh;

    i2s_capture u_capture (
        .adc_clk, .reset, .aud_bclk, .aud_adclrck, .aud_adcdat,
        .credit_return, .sample_push, .sample_data, .overrun_inc
    );

    credit_fifo u_fifo (
        .adc_clk, .reset, .sample_push, .sample_data,
        .fifo_pop, .fifo_valid, .fifo_data, .credit_return
    );

    zero_cross_pitch u_pitch (
        .adc_clk, .reset, .fifo_valid, .fifo_data, .thresh,
        .fifo_pop, .pitch_valid, .pitch_bin
    );

    bell_band_regs u_regs (
        .adc_clk, .reset, .cfg_we, .cfg_addr, .cfg_wdata, .overrun_inc,
        .cfg_rdata, .k_min, .k_max, .thresh
    );

    bell_detector u_detect (
        .adc_clk, .reset, .pitch_valid, .pitch_bin, .k_min, .k_max,
        .bell_detected, .pitch_valid_out, .pitch_bin_out
    );

endmodule

//--- verification/bell_detect_sva.sv
`timescale 1ns/1ps

module credit_fifo_checks
    import bell_audio_pkg::*;
(
    input logic                  adc_clk,
    input logic                  reset,
    input logic                  sample_push,
    input logic                  fifo_pop,
    input logic                  credit_return,
    input logic                  full,
    input logic                  empty,
    input logic [FIFO_PTR_W-1:0] wr_ptr,
    input logic [FIFO_PTR_W-1:0] rd_ptr,
    input logic [CREDIT_W-1:0]   count
);

    logic assert_fail;   // Set once any property fails

    initial assert_fail = 1'b0;

    // Sender holds no credit when the FIFO is full
    no_push_when_full: assert property (@(posedge adc_clk) disable iff (reset)
        full |-> !sample_push)
        else begin
            assert_fail = 1'b1;
            $error("sample pushed into a full FIFO");
        end

    // Occupancy bounded by depth and in step with the pointer distance
    occupancy_in_range: assert property (@(posedge adc_clk) disable iff (reset)
        (count <= CREDIT_W'(FIFO_DEPTH))
        && (count[FIFO_PTR_W-1:0] == FIFO_PTR_W'(wr_ptr - rd_ptr)))
        else begin
            assert_fail = 1'b1;
            $error("FIFO occupancy above depth or out of step with the pointers");
        end

    // A credit only comes back for an entry that was really freed
    no_credit_when_empty: assert property (@(posedge adc_clk) disable iff (reset)
        empty |-> !(fifo_pop || credit_return))
        else begin
            assert_fail = 1'b1;
            $error("pop or credit from an empty FIFO");
        end

endmodule

bind credit_fifo credit_fifo_checks u_checks (
    .adc_clk, .reset, .sample_push, .fifo_pop, .credit_return, .full, .empty,
    .wr_ptr, .rd_ptr, .count
);

//--- verification/tb_bell_detect.sv
`timescale 1ns/1ps

module tb_bell_detect
    import bell_audio_pkg::*;
();

    localparam int     CLK_PERIOD     = 10;
    localparam int     MAX_PATTERNS   = 16;
    localparam longint TIMEOUT_MARGIN = 100_000;     // ns on top of the streaming time

    logic                  adc_clk;
    logic                  reset;
    logic                  aud_bclk;
    logic                  aud_adclrck;
    logic                  aud_adcdat;
    logic                  cfg_we;
    logic [CFG_ADDR_W-1:0] cfg_addr;
    logic [CFG_DATA_W-1:0] cfg_wdata;
    logic [CFG_DATA_W-1:0] cfg_rdata;
    logic                  bell_detected;
    logic                  pitch_valid_out;
    bin_t                  pitch_bin_out;

    logic [31:0] lfsr_state;                 // Right slot filler bits
    int          num_patterns;
    int          results_seen;
    int          p_period[MAX_PATTERNS];
    int          p_amp[MAX_PATTERNS];
    int          p_kmin[MAX_PATTERNS];
    int          p_kmax[MAX_PATTERNS];
    int          p_thresh[MAX_PATTERNS];
    int          p_bin[MAX_PATTERNS];
    int          p_bell[MAX_PATTERNS];
    logic [31:0] got_bin[MAX_PATTERNS];
    logic        got_bell[MAX_PATTERNS];

    bell_detect_top dut (
        .adc_clk, .reset, .aud_bclk, .aud_adclrck, .aud_adcdat, .cfg_we, .cfg_addr,
        .cfg_wdata, .cfg_rdata, .bell_detected, .pitch_valid_out, .pitch_bin_out
    );

    initial begin
        adc_clk = 1'b0;
        forever #(CLK_PERIOD / 2) adc_clk = ~adc_clk;
    end

    // Galois form, taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // Expected bin from the square wave: 128/P - 1 crossings round to 64/P
    function automatic int model_bin(input int period, input int amp, input int thr);
        return (amp > thr) ? FRAME_LEN / period : 0;   // Inside hysteresis no sign change
    endfunction

    task automatic fail_run();
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s, got %0d expected %0d",
                     $time, what, actual, expected);
            fail_run();
        end
    endtask

    task automatic write_reg(input logic [CFG_ADDR_W-1:0] addr, input int data);
        @(negedge adc_clk);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = CFG_DATA_W'(data);
        @(negedge adc_clk);
        cfg_we    = 1'b0;                    // Write landed on the rising edge between
    endtask

    task automatic read_check(input logic [CFG_ADDR_W-1:0] addr, input int expected,
                              input string what);
        @(negedge adc_clk);
        cfg_addr = addr;
        @(negedge adc_clk);
        check_value(cfg_rdata, expected, what);   // Read port is combinational
    endtask

    // One bclk period, 4 cycles low then 4 high, data changes with the fall
    task automatic send_bit(input logic lrck, input logic data);
        @(negedge adc_clk);
        aud_bclk    = 1'b0;
        aud_adclrck = lrck;
        aud_adcdat  = data;
        repeat (4) @(negedge adc_clk);
        aud_bclk    = 1'b1;
        repeat (3) @(negedge adc_clk);
    endtask

    task automatic send_filler(input logic lrck);
        lfsr_state = lfsr_step(lfsr_state);  // One step per bit
        send_bit(lrck, lfsr_state[0]);
    endtask

    // 32 bclk periods per stereo sample
    task automatic send_sample(input logic [SAMPLE_W-1:0] word);
        send_filler(1'b0);                   // One-bit delay after lrck falls
        for (int i = SAMPLE_W - 1; i >= 0; i--)
            send_bit(i == 0, word[i]);       // LSB sits in the first right-slot bit
        for (int i = 0; i < SAMPLE_W - 1; i++)
            send_filler(1'b1);
    endtask

    task automatic send_frame(input int period, input int amp);
        int value;
        for (int s = 0; s < FRAME_LEN; s++) begin
            value = ((s % period) < (period / 2)) ? amp : -amp;   // High half first
            send_sample(SAMPLE_W'(value));
        end
    endtask

    // Collect each pitch result where outputs are settled
    always @(negedge adc_clk) begin
        if (!reset && pitch_valid_out) begin
            if (results_seen >= num_patterns) begin
                $display("ERROR: pitch result at %0t with no frame left to send", $time);
                fail_run();
            end
            got_bin[results_seen]  = 32'(pitch_bin_out);
            got_bell[results_seen] = bell_detected;
            results_seen++;
        end
    end

    // Bound FIFO checker
    initial begin
        wait (dut.u_fifo.u_checks.assert_fail === 1'b1);
        $display("ERROR: a credit FIFO assertion failed at %0t", $time);
        fail_run();
    end

    initial begin
        int    fd;
        int    mbin;
        int    prev_bell;
        string line;
        reset        = 1'b1;
        aud_bclk     = 1'b0;
        aud_adclrck  = 1'b1;                 // Right slot idle
        aud_adcdat   = 1'b0;
        cfg_we       = 1'b0;
        cfg_addr     = '0;
        cfg_wdata    = '0;
        lfsr_state   = 32'h461;
        results_seen = 0;
        fd = $fopen("verification/bell_patterns.txt", "r");
        if (fd == 0) begin
            $display("ERROR: could not open verification/bell_patterns.txt");
            fail_run();
        end
        while (!$feof(fd) && num_patterns < MAX_PATTERNS) begin
            line = "";
            void'($fgets(line, fd));
            // Comment and blank lines do not scan to seven numbers
            if ($sscanf(line, "%d %d %d %d %d %d %d", p_period[num_patterns],
                        p_amp[num_patterns], p_kmin[num_patterns], p_kmax[num_patterns],
                        p_thresh[num_patterns], p_bin[num_patterns],
                        p_bell[num_patterns]) == 7)
                num_patterns++;
        end
        $fclose(fd);
        if (num_patterns == 0) begin
            $display("ERROR: no test frames found in the pattern file");
            fail_run();
        end
        repeat (4) @(negedge adc_clk);
        reset = 1'b0;

        read_check(REG_K_MIN, 6, "k_min after reset");
        read_check(REG_K_MAX, 10, "k_max after reset");
        read_check(REG_THRESH, 256, "thresh after reset");
        read_check(REG_OVERRUN, 0, "overrun count after reset");
        prev_bell = 0;
        send_filler(1'b1);                   // Lets the capture see lrck high first
        send_filler(1'b1);

        for (int i = 0; i < num_patterns; i++) begin
            mbin = model_bin(p_period[i], p_amp[i], p_thresh[i]);
            check_value(p_bin[i], mbin, $sformatf("file bin of pattern %0d", i));
            check_value(p_bell[i], (mbin >= p_kmin[i]) && (mbin <= p_kmax[i]),
                        $sformatf("file bell flag of pattern %0d", i));
            write_reg(REG_K_MIN, p_kmin[i]);
            write_reg(REG_K_MAX, p_kmax[i]);
            write_reg(REG_THRESH, p_thresh[i]);
            check_value(bell_detected, prev_bell, "bell_detected held between frames");
            send_frame(p_period[i], p_amp[i]);
            wait (results_seen > i);         // Result lands during the last right slot
            check_value(got_bin[i], mbin, $sformatf("pitch bin of pattern %0d", i));
            check_value(got_bell[i], p_bell[i], $sformatf("bell flag of pattern %0d", i));
            prev_bell = p_bell[i];
        end

        read_check(REG_OVERRUN, 0, "overrun count after all patterns");
        $display("PASS: all tests");
        $finish;
    end

    // Watchdog, sized from the streaming time of all frames
    initial begin
        longint limit_ns;
        wait (reset === 1'b0);               // Pattern count is final by then
        limit_ns = longint'(num_patterns) * FRAME_LEN * 32 * 8 * CLK_PERIOD + TIMEOUT_MARGIN;
        #(limit_ns);
        $display("ERROR: run timed out at %0t before all pitch results arrived", $time);
        fail_run();
    end

endmodule

//--- verification/bell_patterns.txt
# period amplitude k_min k_max thresh expected_bin expected_bell
# One line per 64-sample frame, all decimal
8 1000 6 10 256 8 1
4 1000 6 10 256 16 0
16 1000 6 10 256 4 0
4 1000 14 20 256 16 1
8 1000 14 20 256 8 0
8 100 6 10 256 0 0
8 100 6 10 16 8 1
2 1000 6 10 256 32 0

//--- files.f
source/bell_audio_pkg.sv
source/i2s_capture.sv
source/credit_fifo.sv
source/zero_cross_pitch.sv
source/bell_band_regs.sv
source/bell_detector.sv
source/bell_detect_top.sv
verification/bell_detect_sva.sv
verification/tb_bell_detect.sv
